// ==== hdl/phased_pkg.sv ====
package phased_pkg;

  ////////////////////
  // array geometry.
  localparam int num_trans = 249;
  localparam int trans_idx_w = 8;

  // host side address widths.
  localparam int normal_addr_w = 9;    // page bit on top of the index.
  localparam int mod_word_addr_w = 14;
  localparam int mod_idx_w = 15;       // one more bit than the word address.

  localparam int byte_w = 8;   // intensity, phase, sample and duty.
  localparam int word_w = 16;  // one bram word.

  ////////////////////
  // plain vector types.
  typedef logic [trans_idx_w-1:0] trans_idx_t;
  typedef logic [normal_addr_w-1:0] normal_addr_t;
  typedef logic [mod_word_addr_w-1:0] mod_word_addr_t;
  typedef logic [mod_idx_w-1:0] mod_idx_t;
  typedef logic [byte_w-1:0] mod_sample_t;

  ////////////////////
  // bus structs.
  typedef struct packed {
    logic [byte_w-1:0] intensity;
    logic [byte_w-1:0] phase;
  } normal_word_t;

  typedef struct packed {
    logic en;
    normal_addr_t addr;
    normal_word_t data;
  } normal_wr_t;

  typedef struct packed {
    logic en;
    logic page;
    mod_word_addr_t addr;
    logic [word_w-1:0] data;  // low byte is the even sample.
  } mod_wr_t;

  typedef struct packed {
    logic valid;
    trans_idx_t idx;
    logic [byte_w-1:0] duty;
    logic [byte_w-1:0] phase;
  } drive_t;

endpackage

// ==== hdl/dp_bram.sv ====
`timescale 1ns/1ps

// simple dual port ram, one write port and one registered read port.
module dp_bram #(
  parameter int width = 16,
  parameter int depth_bits = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic [depth_bits-1:0] wr_addr,
  input  logic [width-1:0]      wr_data,
  input  logic [depth_bits-1:0] rd_addr,
  output logic [width-1:0]      rd_data
);

  logic [width-1:0] mem [2**depth_bits];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // read register, new data visible the cycle after a write.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hdl/trans_scanner.sv ====
`timescale 1ns/1ps

// walks the transducer indices, one per cycle, with no gap between scans.
module trans_scanner import phased_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable,
  output trans_idx_t scan_idx,
  output logic       scan_wrap
);

  logic last_idx;

  assign last_idx = (scan_idx == trans_idx_t'(num_trans - 1));

  ////////////////////
  // index counter.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_idx <= '0;
    end else if (!enable) begin
      scan_idx <= '0;  // parked at the first element.
    end else if (last_idx) begin
      scan_idx <= '0;
    end else begin
      scan_idx <= scan_idx + 1'b1;
    end
  end

  // high during the last index of a running scan.
  assign scan_wrap = enable & last_idx;

endmodule

// ==== hdl/modulator.sv ====
`timescale 1ns/1ps

// modulation sample index, one step per completed scan.
module modulator import phased_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable,
  input  logic     scan_wrap,
  input  mod_idx_t mod_cycle,
  output mod_idx_t mod_idx
);

  logic     at_last;
  mod_idx_t next_idx;

  assign at_last = (mod_idx == mod_cycle);

  // next sample, back to zero after the last one.
  always_comb begin
    if (at_last) begin
      next_idx = '0;
    end else begin
      next_idx = mod_idx + 1'b1;
    end
  end

  ////////////////////
  // sample index register.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mod_idx <= '0;
    end else if (!enable) begin
      mod_idx <= '0;  // every run starts at sample 0.
    end else if (scan_wrap) begin
      mod_idx <= next_idx;
    end
  end

endmodule

// ==== hdl/memory.sv ====
`timescale 1ns/1ps

module memory import phased_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  normal_wr_t   normal_wr,
  input  mod_wr_t      mod_wr,
  input  logic         normal_page_sel,
  input  logic         mod_page_sel,
  input  trans_idx_t   scan_idx,
  input  mod_idx_t     mod_idx,
  output normal_word_t normal_value,
  output mod_sample_t  mod_value
);

  ////////////////////
  // normal banks.
  logic         normal_page;
  logic         normal_we_0;
  logic         normal_we_1;
  trans_idx_t   normal_addr;
  normal_word_t normal_rd_0;
  normal_word_t normal_rd_1;

  assign normal_page = normal_wr.addr[normal_addr_w-1];  // top bit picks the bank.
  assign normal_addr = normal_wr.addr[trans_idx_w-1:0];
  assign normal_we_0 = normal_wr.en & ~normal_page;
  assign normal_we_1 = normal_wr.en & normal_page;

  dp_bram #(.width(word_w), .depth_bits(trans_idx_w)) normal_bram_0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (normal_we_0),
    .wr_addr(normal_addr),
    .wr_data(normal_wr.data),
    .rd_addr(scan_idx),
    .rd_data(normal_rd_0)
  );

  dp_bram #(.width(word_w), .depth_bits(trans_idx_w)) normal_bram_1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (normal_we_1),
    .wr_addr(normal_addr),
    .wr_data(normal_wr.data),
    .rd_addr(scan_idx),
    .rd_data(normal_rd_1)
  );

  assign normal_value = normal_page_sel ? normal_rd_1 : normal_rd_0;

  ////////////////////
  // modulation banks.
  logic              mod_we_0;
  logic              mod_we_1;
  mod_word_addr_t    mod_rd_addr;
  logic [word_w-1:0] mod_rd_0;
  logic [word_w-1:0] mod_rd_1;
  logic [word_w-1:0] mod_word;
  logic              byte_sel_q;

  assign mod_we_0 = mod_wr.en & ~mod_wr.page;
  assign mod_we_1 = mod_wr.en & mod_wr.page;
  assign mod_rd_addr = mod_idx[mod_idx_w-1:1];  // two samples per word.

  dp_bram #(.width(word_w), .depth_bits(mod_word_addr_w)) mod_bram_0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (mod_we_0),
    .wr_addr(mod_wr.addr),
    .wr_data(mod_wr.data),
    .rd_addr(mod_rd_addr),
    .rd_data(mod_rd_0)
  );

  dp_bram #(.width(word_w), .depth_bits(mod_word_addr_w)) mod_bram_1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (mod_we_1),
    .wr_addr(mod_wr.addr),
    .wr_data(mod_wr.data),
    .rd_addr(mod_rd_addr),
    .rd_data(mod_rd_1)
  );

  // byte select follows the bram read latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_sel_q <= 1'b0;
    end else begin
      byte_sel_q <= mod_idx[0];
    end
  end

  assign mod_word = mod_page_sel ? mod_rd_1 : mod_rd_0;
  assign mod_value = byte_sel_q ? mod_word[word_w-1:byte_w] : mod_word[byte_w-1:0];

endmodule

// ==== hdl/drive_calc.sv ====
`timescale 1ns/1ps

module drive_calc import phased_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         enable,
  input  trans_idx_t   scan_idx,
  input  normal_word_t normal_value,
  input  mod_sample_t  mod_value,
  output drive_t       drive
);

  logic              enable_q;
  trans_idx_t        idx_q;
  logic [word_w-1:0] product;

  // match the memory read latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q <= 1'b0;
      idx_q <= '0;
    end else begin
      enable_q <= enable;
      idx_q <= scan_idx;
    end
  end

  assign product = normal_value.intensity * mod_value;  // full 16 bit result.

  ////////////////////
  // output register.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drive <= '0;
    end else begin
      drive.valid <= enable_q;
      drive.idx <= idx_q;
      drive.duty <= product[word_w-1:byte_w];  // top byte only.
      drive.phase <= normal_value.phase;
    end
  end

endmodule

// ==== hdl/phased_top.sv ====
`timescale 1ns/1ps

// drive core: scanner and modulator address the banks, drive_calc scales.
module phased_top import phased_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable,
  input  logic       normal_page_sel,
  input  logic       mod_page_sel,
  input  mod_idx_t   mod_cycle,
  input  normal_wr_t normal_wr,
  input  mod_wr_t    mod_wr,
  output drive_t     drive
);

  trans_idx_t   scan_idx;
  logic         scan_wrap;
  mod_idx_t     mod_idx;
  normal_word_t normal_value;
  mod_sample_t  mod_value;

  trans_scanner i_trans_scanner (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .scan_idx (scan_idx),
    .scan_wrap(scan_wrap)
  );

  modulator i_modulator (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .scan_wrap(scan_wrap),
    .mod_cycle(mod_cycle),
    .mod_idx  (mod_idx)
  );

  // one cycle read latency on both outputs.
  memory i_memory (
    .clk            (clk),
    .rst_n          (rst_n),
    .normal_wr      (normal_wr),
    .mod_wr         (mod_wr),
    .normal_page_sel(normal_page_sel),
    .mod_page_sel   (mod_page_sel),
    .scan_idx       (scan_idx),
    .mod_idx        (mod_idx),
    .normal_value   (normal_value),
    .mod_value      (mod_value)
  );

  drive_calc i_drive_calc (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .scan_idx    (scan_idx),
    .normal_value(normal_value),
    .mod_value   (mod_value),
    .drive       (drive)
  );

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// result counters.
int unsigned pass_count = 0;
int unsigned fail_count = 0;

// compares the payload fields of one drive word.
task automatic check_drive(input string name, input drive_t exp, input drive_t act);
  bit ok;
  ok = (exp.idx == act.idx) && (exp.duty == act.duty) && (exp.phase == act.phase);
  if (ok) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("error %s: expected idx %0d duty %0d phase %0d, actual idx %0d duty %0d phase %0d",
             name, exp.idx, exp.duty, exp.phase, act.idx, act.duty, act.phase);
  end
endtask

// valid bit only.
task automatic check_valid(input string name, input logic exp, input logic act);
  if (exp === act) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("error %s: expected valid %0b, actual valid %0b", name, exp, act);
  end
endtask

`endif

// ==== testbench/tb_phased_top.sv ====
`timescale 1ns/1ps

module tb_phased_top import phased_pkg::*; ();

  `include "tb_checks.svh"

  localparam int mod_words = 16;  // samples 0 to 31 are loaded.

  logic       clk;
  logic       rst_n;
  logic       enable;
  logic       normal_page_sel;
  logic       mod_page_sel;
  mod_idx_t   mod_cycle;
  normal_wr_t normal_wr;
  mod_wr_t    mod_wr;
  drive_t     drive;

  normal_word_t normal_ref [2][256];
  mod_sample_t  mod_ref [2][2*mod_words];

  ////////////////////
  // stimulus table.
  string    t_name [$];
  bit       t_npage [$];
  bit       t_mpage [$];
  mod_idx_t t_cycle [$];
  int       t_scan [$];
  int       t_trans [$];
  drive_t   t_expected [$];

  phased_top i_phased_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .normal_page_sel(normal_page_sel),
    .mod_page_sel   (mod_page_sel),
    .mod_cycle      (mod_cycle),
    .normal_wr      (normal_wr),
    .mod_wr         (mod_wr),
    .drive          (drive)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // duty is the top byte of intensity times the sample of this scan.
  function automatic drive_t expected_drive(input bit np, input bit mp, input mod_idx_t cyc,
                                            input int scan, input int trans);
    normal_word_t nw;
    int           prod;
    drive_t       d;
    nw = normal_ref[np][trans];
    prod = int'(nw.intensity) * int'(mod_ref[mp][scan % (int'(cyc) + 1)]);
    d.valid = 1'b1;
    d.idx = trans_idx_t'(trans);
    d.duty = 8'(prod / 256);
    d.phase = nw.phase;
    return d;
  endfunction

  task automatic add_test(input string name, input bit np, input bit mp, input mod_idx_t cyc,
                          input int scan, input int trans);
    t_name.push_back(name);
    t_npage.push_back(np);
    t_mpage.push_back(mp);
    t_cycle.push_back(cyc);
    t_scan.push_back(scan);
    t_trans.push_back(trans);
    t_expected.push_back(expected_drive(np, mp, cyc, scan, trans));
  endtask

  task automatic build_table();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 256; i++) begin
        normal_ref[p][i] = normal_word_t'($urandom());
      end
      for (int s = 0; s < 2*mod_words; s++) begin
        mod_ref[p][s] = (p == 0) ? 8'hff : mod_sample_t'($urandom());  // page 0 full scale.
      end
    end
    normal_ref[1][17] = ~normal_ref[0][17];
    mod_ref[1][0] = 8'h40;
    mod_ref[1][1] = 8'h90;
    mod_ref[1][2] = 8'hd7;
    add_test("full_scale_idx0", 1'b0, 1'b0, '0, 0, 0);
    add_test("full_scale_idx100", 1'b0, 1'b0, '0, 1, 100);
    add_test("full_scale_idx248", 1'b0, 1'b0, '0, 0, 248);
    add_test("page0_idx17", 1'b0, 1'b0, '0, 0, 17);
    add_test("page1_idx17", 1'b1, 1'b1, '0, 0, 17);
    for (int s = 0; s < 5; s++) begin
      add_test($sformatf("cycle_wrap_scan%0d", s), 1'b0, 1'b1, mod_idx_t'(2), s, 0);
    end
    for (int k = 0; k < 10; k++) begin
      add_test($sformatf("random_%0d", k), bit'($urandom_range(1)), 1'b1,
               mod_idx_t'($urandom_range(9, 3)), $urandom_range(5), $urandom_range(248));
    end
  endtask

  // host writes one word per cycle into both pages.
  task automatic load_memories();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < num_trans; i++) begin
        @(posedge clk);
        mod_wr <= '0;
        normal_wr <= '{en: 1'b1, addr: normal_addr_t'({p[0], i[7:0]}), data: normal_ref[p][i]};
      end
      for (int w = 0; w < mod_words; w++) begin
        @(posedge clk);
        normal_wr <= '0;
        mod_wr <= '{en: 1'b1, page: p[0], addr: mod_word_addr_t'(w),
                    data: {mod_ref[p][2*w+1], mod_ref[p][2*w]}};
      end
    end
    @(posedge clk);
    normal_wr <= '0;
    mod_wr <= '0;
  endtask

  task automatic start_run(input bit np, input bit mp, input mod_idx_t cyc);
    @(posedge clk);
    normal_page_sel <= np;
    mod_page_sel <= mp;
    mod_cycle <= cyc;
    @(posedge clk);
    enable <= 1'b1;
  endtask

  task automatic stop_run();
    @(posedge clk);
    enable <= 1'b0;
    repeat (3) @(posedge clk);  // valid trails enable by two cycles.
  endtask

  // scans are counted by idx 0 on the output.
  task automatic wait_drive(input int scan, input int trans, output drive_t got,
                            output bit found);
    int scans_seen;
    int limit;
    scans_seen = -1;
    found = 1'b0;
    got = '0;
    limit = (scan + 2) * num_trans + 20;
    for (int c = 0; c < limit && !found; c++) begin
      @(negedge clk);
      if (drive.valid && drive.idx == '0) scans_seen++;
      if (drive.valid && scans_seen == scan && drive.idx == trans_idx_t'(trans)) begin
        got = drive;
        found = 1'b1;
      end
    end
    if (!found) begin
      fail_count++;
      $display("timeout: no drive word for scan %0d transducer %0d", scan, trans);
    end
  endtask

  task automatic report_test(input string name, input int unsigned fails_before);
    $display("test %s: %s", name, (fail_count == fails_before) ? "ok" : "failed");
  endtask

  ////////////////////
  // main sequence.
  initial begin
    drive_t      got;
    bit          found;
    int unsigned fails_before;
    rst_n = 1'b0;
    enable = 1'b0;
    normal_page_sel = 1'b0;
    mod_page_sel = 1'b0;
    mod_cycle = '0;
    normal_wr = '0;
    mod_wr = '0;
    void'($urandom(61));
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    fails_before = fail_count;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      check_valid("reset_idle", 1'b0, drive.valid);
    end
    report_test("reset_idle", fails_before);

    for (int k = 0; k < t_name.size(); k++) begin
      fails_before = fail_count;
      stop_run();
      load_memories();
      start_run(t_npage[k], t_mpage[k], t_cycle[k]);
      wait_drive(t_scan[k], t_trans[k], got, found);
      if (found) check_drive(t_name[k], t_expected[k], got);
      report_test(t_name[k], fails_before);
    end

    // one full scan back to back and the wrap to idx 0.
    fails_before = fail_count;
    stop_run();
    start_run(1'b0, 1'b0, '0);
    found = 1'b0;
    for (int c = 0; c < 20 && !found; c++) begin
      @(negedge clk);
      found = drive.valid;
    end
    if (!found) begin
      fail_count++;
      $display("timeout: drive valid never rose in output_sequence");
    end else begin
      for (int i = 0; i <= num_trans; i++) begin
        check_valid("output_sequence", 1'b1, drive.valid);
        check_drive("output_sequence",
                    expected_drive(1'b0, 1'b0, '0, i / num_trans, i % num_trans), drive);
        @(negedge clk);
      end
    end
    report_test("output_sequence", fails_before);
    stop_run();

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
hdl/phased_pkg.sv
hdl/dp_bram.sv
hdl/trans_scanner.sv
hdl/modulator.sv
hdl/memory.sv
hdl/drive_calc.sv
hdl/phased_top.sv
testbench/tb_phased_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f compile.f --top-module tb_phased_top -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1
